/* Makefile */
# Verilator build and run of the gnn_accel testbench

SOURCES := gnn_accel.f $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all run clean

all: obj_dir/Vgnn_accel_tb

# rebuilt only when a source or the file list changes
obj_dir/Vgnn_accel_tb: $(SOURCES)
	verilator --binary -Wno-fatal -f gnn_accel.f --top-module gnn_accel_tb -o Vgnn_accel_tb

# the pass line decides the exit status
run: obj_dir/Vgnn_accel_tb
	@out="$$(./obj_dir/Vgnn_accel_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* gnn_accel.f */
+incdir+source
source/gnn_pkg.sv
source/gnn_if.sv
source/packet_decoder.sv
source/edge_pe.sv
source/agg_arbiter.sv
source/vertex_unit.sv
source/gnn_accel.sv
test/gnn_accel_checker.sv
test/gnn_accel_tb.sv

/* source/agg_arbiter.sv */
`default_nettype none

`include "gnn_settings.svh"

module agg_arbiter (
    input  wire logic         clk,
    input  wire logic         arst_n,
    agg_if.arbiter            agg [`GNN_NUM_EDGE_PE],
    output logic              sel_valid,
    output gnn_pkg::node_id_t sel_node_id,
    output gnn_pkg::acc_t     sel_sum,
    output gnn_pkg::fv_t      sel_weight
);

    localparam int num_pe = `GNN_NUM_EDGE_PE;
    localparam int idx_bits = (num_pe > 1) ? $clog2(num_pe) : 1;

    logic [num_pe-1:0] done_vec;
    logic [num_pe-1:0] grant_vec;
    gnn_pkg::node_id_t node_ids [num_pe];
    gnn_pkg::acc_t sums [num_pe];
    gnn_pkg::fv_t weights [num_pe];
    logic [idx_bits-1:0] ptr_q;
    logic [idx_bits-1:0] win_idx;

    for (genvar g = 0; g < num_pe; g++) begin : g_req
        assign done_vec[g] = agg[g].done;
        assign node_ids[g] = agg[g].node_id;
        assign sums[g]     = agg[g].sum;
        assign weights[g]  = agg[g].weight;
        assign agg[g].grant = grant_vec[g];
    end

    // search starts at the pointer and wraps
    always_comb begin
        int cand;
        sel_valid = 1'b0;
        win_idx   = '0;
        grant_vec = '0;
        for (int i = 0; i < num_pe; i++) begin
            cand = (int'(ptr_q) + i) % num_pe;
            if (!sel_valid && done_vec[cand]) begin
                sel_valid = 1'b1;
                win_idx   = idx_bits'(cand);
            end
        end
        if (sel_valid) begin
            grant_vec[win_idx] = 1'b1;
        end
    end

    // winner fields straight through
    assign sel_node_id = node_ids[win_idx];
    assign sel_sum     = sums[win_idx];
    assign sel_weight  = weights[win_idx];

    // next search begins one past the winner
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_q <= '0;
        end else if (sel_valid) begin
            ptr_q <= (int'(win_idx) == num_pe - 1) ? '0 : win_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/edge_pe.sv */
`default_nettype none

module edge_pe (
    input  wire logic clk,
    input  wire logic arst_n,
    edge_task_if.pe   edge_task,
    agg_if.pe         agg
);

    // control state
    logic idle_q;
    logic done_q;
    gnn_pkg::count_t left_q;

    // node payload
    gnn_pkg::node_id_t node_id_q;
    gnn_pkg::fv_t weight_q;
    gnn_pkg::acc_t sum_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_q <= 1'b1;
            done_q <= 1'b0;
            left_q <= '0;
        end else begin
            if (edge_task.task_valid) begin
                // busy from here until the result is taken
                idle_q <= 1'b0;
                left_q <= edge_task.task_count;
            end else if (edge_task.fv_valid && left_q != '0) begin
                left_q <= left_q - 1'b1;
                // last neighbour just arrived
                if (left_q == gnn_pkg::count_t'(1)) begin
                    done_q <= 1'b1;
                end
            end
            // arbiter took the sum
            if (done_q && agg.grant) begin
                done_q <= 1'b0;
                idle_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (edge_task.task_valid) begin
            node_id_q <= edge_task.task_node_id;
            weight_q  <= edge_task.task_weight;
            sum_q     <= '0;
        end else if (edge_task.fv_valid && left_q != '0) begin
            // sign extended feature into the wider sum
            sum_q <= sum_q + gnn_pkg::acc_t'(edge_task.fv_data);
        end
    end

    assign edge_task.idle = idle_q;

    // fields are stable while done is high
    assign agg.done    = done_q;
    assign agg.node_id = node_id_q;
    assign agg.sum     = sum_q;
    assign agg.weight  = weight_q;

endmodule

`default_nettype wire

/* source/gnn_accel.sv */
`default_nettype none

`include "gnn_settings.svh"

module gnn_accel (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             pkt_valid,
    input  wire gnn_pkg::packet_t pkt_data,
    output logic                  pkt_ready,
    output logic                  out_valid,
    output gnn_pkg::node_id_t     out_node_id,
    output gnn_pkg::result_t      out_value,
    output logic                  task_complete
);

    // one link of each kind per edge PE
    edge_task_if task_bus [`GNN_NUM_EDGE_PE] ();
    agg_if       agg_bus  [`GNN_NUM_EDGE_PE] ();

    // arbiter to vertex unit
    logic sel_valid;
    gnn_pkg::node_id_t sel_node_id;
    gnn_pkg::acc_t sel_sum;
    gnn_pkg::fv_t sel_weight;
    logic vertex_idle;

    // decode stage
    packet_decoder packet_decoder_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .pkt_valid     (pkt_valid),
        .pkt_data      (pkt_data),
        .vertex_idle   (vertex_idle),
        .pkt_ready     (pkt_ready),
        .task_complete (task_complete),
        .tasks         (task_bus)
    );

    // execute stage, one accumulator per PE
    for (genvar g = 0; g < `GNN_NUM_EDGE_PE; g++) begin : g_edge_pe
        edge_pe edge_pe_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .edge_task (task_bus[g]),
            .agg       (agg_bus[g])
        );
    end

    // finished sums queue here
    agg_arbiter agg_arbiter_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .agg         (agg_bus),
        .sel_valid   (sel_valid),
        .sel_node_id (sel_node_id),
        .sel_sum     (sel_sum),
        .sel_weight  (sel_weight)
    );

    // result stage
    vertex_unit vertex_unit_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .sel_valid   (sel_valid),
        .sel_node_id (sel_node_id),
        .sel_sum     (sel_sum),
        .sel_weight  (sel_weight),
        .out_valid   (out_valid),
        .out_node_id (out_node_id),
        .out_value   (out_value),
        .vertex_idle (vertex_idle)
    );

endmodule

`default_nettype wire

/* source/gnn_if.sv */
`default_nettype none

// decoder to one edge PE
// strobes last one cycle, idle is a level
interface edge_task_if;
    logic task_valid;
    gnn_pkg::node_id_t task_node_id;
    gnn_pkg::count_t task_count;
    gnn_pkg::fv_t task_weight;
    logic fv_valid;
    gnn_pkg::fv_t fv_data;
    logic idle;

    modport decoder (
        output task_valid, task_node_id, task_count, task_weight,
        output fv_valid, fv_data,
        input  idle
    );

    modport pe (
        input  task_valid, task_node_id, task_count, task_weight,
        input  fv_valid, fv_data,
        output idle
    );
endinterface

// one edge PE to the arbiter
// done and fields hold until grant
interface agg_if;
    logic done;
    gnn_pkg::node_id_t node_id;
    gnn_pkg::acc_t sum;
    gnn_pkg::fv_t weight;
    logic grant;

    modport pe (output done, node_id, sum, weight, input grant);
    modport arbiter (input done, node_id, sum, weight, output grant);
endinterface

`default_nettype wire

/* source/gnn_pkg.sv */
`default_nettype none

`include "gnn_settings.svh"

package gnn_pkg;

    // top two packet bits
    typedef enum logic [1:0] {
        op_weight_load = 2'd0,
        op_node_header = 2'd1,
        op_feature     = 2'd2,
        op_end_stream  = 2'd3
    } opcode_t;

    typedef logic [`GNN_PACKET_SIZE-1:0] packet_t;
    typedef logic [`GNN_NODE_ID_BITS-1:0] node_id_t;
    typedef logic [`GNN_COUNT_BITS-1:0] count_t;

    // feature and weight share one signed width
    typedef logic signed [`GNN_FV_SIZE-1:0] fv_t;
    typedef logic signed [`GNN_ACC_BITS-1:0] acc_t;
    typedef logic signed [`GNN_OUT_BITS-1:0] result_t;

    // node header layout
    // bits 13..8 node id, bits 3..0 neighbour count
    typedef struct packed {
        opcode_t opcode;
        node_id_t node_id;
        logic [`GNN_PACKET_SIZE-2-`GNN_NODE_ID_BITS-`GNN_COUNT_BITS-1:0] rsvd;
        count_t count;
    } header_pkt_t;

    // weight load and feature layout
    // low byte carries the signed value
    typedef struct packed {
        opcode_t opcode;
        logic [`GNN_PACKET_SIZE-2-`GNN_FV_SIZE-1:0] rsvd;
        fv_t value;
    } value_pkt_t;

endpackage

`default_nettype wire

/* source/gnn_settings.svh */
`ifndef GNN_SETTINGS_SVH
`define GNN_SETTINGS_SVH

// edge PEs working in parallel
`define GNN_NUM_EDGE_PE 2

// raw instruction packet
`define GNN_PACKET_SIZE 16

// signed feature and weight values
`define GNN_FV_SIZE 8

// node id and neighbour count fields
`define GNN_NODE_ID_BITS 6
`define GNN_COUNT_BITS 4

// 15 features of 8 bits fit in 12 signed bits
`define GNN_ACC_BITS 12
`define GNN_OUT_BITS 20

`endif

/* source/packet_decoder.sv */
`default_nettype none

`include "gnn_settings.svh"

module packet_decoder (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             pkt_valid,
    input  wire gnn_pkg::packet_t pkt_data,
    input  wire logic             vertex_idle,
    output logic                  pkt_ready,
    output logic                  task_complete,
    edge_task_if.decoder          tasks [`GNN_NUM_EDGE_PE]
);

    localparam int num_pe = `GNN_NUM_EDGE_PE;
    localparam int idx_bits = (num_pe > 1) ? $clog2(num_pe) : 1;

    gnn_pkg::header_pkt_t hdr;
    gnn_pkg::value_pkt_t val;
    logic header_acc;
    logic feature_acc;
    logic [num_pe-1:0] pe_idle;
    logic any_idle;
    logic [idx_bits-1:0] free_idx;

    // control state
    gnn_pkg::fv_t weight_q;
    gnn_pkg::count_t remaining_q;
    logic [idx_bits-1:0] owner_q;
    logic eos_q;
    logic [num_pe-1:0] task_valid_q;
    logic [num_pe-1:0] fv_valid_q;

    // payload toward the PEs, shared by all of them
    gnn_pkg::node_id_t task_node_id_q;
    gnn_pkg::count_t task_count_q;
    gnn_pkg::fv_t task_weight_q;
    gnn_pkg::fv_t fv_data_q;

    // same bits, two views
    assign hdr = gnn_pkg::header_pkt_t'(pkt_data);
    assign val = gnn_pkg::value_pkt_t'(pkt_data);

    assign header_acc = pkt_valid && (hdr.opcode == gnn_pkg::op_node_header);
    // stray features with no open node are dropped
    assign feature_acc = pkt_valid && (hdr.opcode == gnn_pkg::op_feature)
                         && (remaining_q != '0);

    // lowest numbered idle PE wins the next header
    always_comb begin
        any_idle = 1'b0;
        free_idx = '0;
        for (int i = num_pe - 1; i >= 0; i--) begin
            if (pe_idle[i]) begin
                any_idle = 1'b1;
                free_idx = idx_bits'(i);
            end
        end
    end

    // an open node always takes its features
    // otherwise a header needs a free PE
    assign pkt_ready = (remaining_q != '0) || any_idle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight_q     <= '0;
            remaining_q  <= '0;
            owner_q      <= '0;
            eos_q        <= 1'b0;
            task_valid_q <= '0;
            fv_valid_q   <= '0;
        end else begin
            // strobes by default
            task_valid_q <= '0;
            fv_valid_q   <= '0;
            if (pkt_valid && hdr.opcode == gnn_pkg::op_weight_load) begin
                weight_q <= val.value;
            end
            if (header_acc) begin
                task_valid_q[free_idx] <= 1'b1;
                owner_q                <= free_idx;
                remaining_q            <= hdr.count;
                // new work reopens the stream
                eos_q                  <= 1'b0;
            end
            if (feature_acc) begin
                fv_valid_q[owner_q] <= 1'b1;
                remaining_q         <= remaining_q - 1'b1;
            end
            if (pkt_valid && hdr.opcode == gnn_pkg::op_end_stream) begin
                eos_q <= 1'b1;
            end
        end
    end

    // weight is the one current at the header
    always_ff @(posedge clk) begin
        if (header_acc) begin
            task_node_id_q <= hdr.node_id;
            task_count_q   <= hdr.count;
            task_weight_q  <= weight_q;
        end
        if (feature_acc) begin
            fv_data_q <= val.value;
        end
    end

    for (genvar g = 0; g < num_pe; g++) begin : g_pe_link
        assign pe_idle[g]              = tasks[g].idle;
        assign tasks[g].task_valid     = task_valid_q[g];
        assign tasks[g].task_node_id   = task_node_id_q;
        assign tasks[g].task_count     = task_count_q;
        assign tasks[g].task_weight    = task_weight_q;
        assign tasks[g].fv_valid       = fv_valid_q[g];
        assign tasks[g].fv_data        = fv_data_q;
    end

    // stream over and nothing left in flight
    assign task_complete = eos_q && (&pe_idle) && vertex_idle;

endmodule

`default_nettype wire

/* source/vertex_unit.sv */
`default_nettype none

`include "gnn_settings.svh"

module vertex_unit (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              sel_valid,
    input  wire gnn_pkg::node_id_t sel_node_id,
    input  wire gnn_pkg::acc_t     sel_sum,
    input  wire gnn_pkg::fv_t      sel_weight,
    output logic                   out_valid,
    output gnn_pkg::node_id_t      out_node_id,
    output gnn_pkg::result_t       out_value,
    output logic                   vertex_idle
);

    gnn_pkg::result_t product;
    gnn_pkg::result_t relu;

    // both operands sign extended to the result width
    // 12 x 8 bits cannot overflow 20
    assign product = gnn_pkg::result_t'(sel_sum) * gnn_pkg::result_t'(sel_weight);

    // negative products clamp to zero
    assign relu = product[`GNN_OUT_BITS-1] ? '0 : product;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            // one cycle after the grant
            out_valid <= sel_valid;
        end
    end

    // result register, only loaded on a grant
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            out_node_id <= sel_node_id;
            out_value   <= relu;
        end
    end

    // busy while a result sits in the register
    assign vertex_idle = !out_valid;

endmodule

`default_nettype wire

/* test/gnn_accel_checker.sv */
`default_nettype none

`include "gnn_settings.svh"

module gnn_accel_checker (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         pkt_valid,
    input  wire logic [`GNN_PACKET_SIZE-1:0]  pkt_data,
    input  wire logic                         pkt_ready,
    input  wire logic                         out_valid,
    input  wire logic [`GNN_NODE_ID_BITS-1:0] out_node_id,
    input  wire logic [`GNN_OUT_BITS-1:0]     out_value,
    input  wire logic                         task_complete,
    input  wire logic                         test_end,
    input  wire logic [8*24-1:0]              test_label,
    input  wire logic [7:0]                   exp_results,
    output int                                error_count,
    output int                                check_count
);

    localparam int num_ids = 2 ** `GNN_NODE_ID_BITS;

    // expected result per node id
    // filled when a node's last feature arrives
    int exp_value [num_ids];
    bit exp_pending [num_ids];

    // packet model
    int weight_m;
    int node_w_m;
    int node_id_m;
    int sum_m;
    int left_m;
    int prod;
    bit eos_m;
    bit first_m;

    // per test bookkeeping
    int pending_m;
    int results_m;
    int test_errors;
    int test_num;
    logic [`GNN_OUT_BITS-1:0] exp_bits;

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_ids; i++) begin
                exp_pending[i] = 1'b0;
                exp_value[i]   = 0;
            end
            weight_m    = 0;
            node_w_m    = 0;
            node_id_m   = 0;
            sum_m       = 0;
            left_m      = 0;
            eos_m       = 1'b0;
            first_m     = 1'b1;
            pending_m   = 0;
            results_m   = 0;
            test_errors = 0;
            test_num    = 0;
            error_count = 0;
            check_count = 0;
        end else begin
            // outputs right after reset
            if (first_m) begin
                first_m = 1'b0;
                if (pkt_ready !== 1'b1) begin
                    $display("CHECK FAILED pkt_ready after reset: expected 1, got %h", pkt_ready);
                    note_error();
                end
                if (out_valid !== 1'b0) begin
                    $display("CHECK FAILED out_valid after reset: expected 0, got %h", out_valid);
                    note_error();
                end
            end
            // completion level against the model
            if (task_complete === 1'b1 && !eos_m) begin
                $display("task_complete is high although no end of stream is pending");
                note_error();
            end
            if (task_complete === 1'b1 && (pending_m != 0 || left_m != 0)) begin
                $display("task_complete is high while results are still outstanding");
                note_error();
            end
            // an open node keeps the input ready for its features
            if (left_m != 0 && pkt_ready !== 1'b1) begin
                $display("CHECK FAILED pkt_ready with features due: expected 1, got %h",
                         pkt_ready);
                note_error();
            end
            // results may come in any order
            // matched by node id
            if (out_valid === 1'b1) begin
                if (!exp_pending[out_node_id]) begin
                    $display("result for node %0d arrived with no result expected", out_node_id);
                    note_error();
                end else begin
                    check_count++;
                    exp_bits = exp_value[out_node_id][`GNN_OUT_BITS-1:0];
                    if (out_value !== exp_bits) begin
                        $display("CHECK FAILED out_value node %0d: expected %h, got %h",
                                 out_node_id, exp_bits, out_value);
                        note_error();
                    end
                    exp_pending[out_node_id] = 1'b0;
                    pending_m--;
                    results_m++;
                end
            end
            if (pkt_valid === 1'b1) begin
                case (pkt_data[`GNN_PACKET_SIZE-1 -: 2])
                    2'd0: weight_m = int'($signed(pkt_data[7:0]));
                    2'd1: begin
                        // weight is frozen at the header
                        node_id_m = int'(pkt_data[13:8]);
                        left_m    = int'(pkt_data[3:0]);
                        node_w_m  = weight_m;
                        sum_m     = 0;
                        eos_m     = 1'b0;
                    end
                    2'd2: begin
                        if (left_m != 0) begin
                            sum_m += int'($signed(pkt_data[7:0]));
                            left_m--;
                            if (left_m == 0) begin
                                prod = sum_m * node_w_m;
                                // relu
                                if (prod < 0) begin
                                    prod = 0;
                                end
                                exp_value[node_id_m]   = prod;
                                exp_pending[node_id_m] = 1'b1;
                                pending_m++;
                            end
                        end
                    end
                    default: eos_m = 1'b1;
                endcase
            end
            if (test_end === 1'b1) begin
                for (int i = 0; i < num_ids; i++) begin
                    if (exp_pending[i]) begin
                        $display("node %0d never produced a result", i);
                        note_error();
                        exp_pending[i] = 1'b0;
                    end
                end
                if (results_m != int'(exp_results)) begin
                    $display("test expected %0d results but saw %0d", exp_results, results_m);
                    note_error();
                end
                $display("test %0d %s: %0d results, %0d errors",
                         test_num, test_label, results_m, test_errors);
                pending_m   = 0;
                results_m   = 0;
                test_errors = 0;
                test_num++;
            end
        end
    end

endmodule

`default_nettype wire

/* test/gnn_accel_tb.sv */
`default_nettype none

`include "gnn_settings.svh"

module gnn_accel_tb;

    localparam int ready_limit    = 100;
    localparam int complete_limit = 200;

    logic clk;
    logic arst_n;
    logic pkt_valid;
    logic [`GNN_PACKET_SIZE-1:0] pkt_data;
    logic pkt_ready;
    logic out_valid;
    logic [`GNN_NODE_ID_BITS-1:0] out_node_id;
    logic [`GNN_OUT_BITS-1:0] out_value;
    logic task_complete;

    // checker side channel
    logic test_end;
    logic [8*24-1:0] test_label;
    logic [7:0] test_exp_count;
    int error_count;
    int check_count;

    // stimulus table, one test is a run of packets plus a result count
    logic [`GNN_PACKET_SIZE-1:0] pkt_table [256];
    int pkt_total;
    int test_first [9];
    int test_exp [8];
    logic [8*24-1:0] test_name [8];
    int test_total;
    integer seed;

    gnn_accel gnn_accel_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .pkt_valid     (pkt_valid),
        .pkt_data      (pkt_data),
        .pkt_ready     (pkt_ready),
        .out_valid     (out_valid),
        .out_node_id   (out_node_id),
        .out_value     (out_value),
        .task_complete (task_complete)
    );

    gnn_accel_checker checker_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .pkt_valid     (pkt_valid),
        .pkt_data      (pkt_data),
        .pkt_ready     (pkt_ready),
        .out_valid     (out_valid),
        .out_node_id   (out_node_id),
        .out_value     (out_value),
        .task_complete (task_complete),
        .test_end      (test_end),
        .test_label    (test_label),
        .exp_results   (test_exp_count),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // packet encoders, opcode in the top two bits
    function automatic logic [15:0] weight_pkt(input int w);
        return {2'd0, 6'd0, 8'(w)};
    endfunction

    function automatic logic [15:0] header_pkt(input int id, input int cnt);
        return {2'd1, 6'(id), 4'd0, 4'(cnt)};
    endfunction

    function automatic logic [15:0] feature_pkt(input int v);
        return {2'd2, 6'd0, 8'(v)};
    endfunction

    function automatic logic [15:0] end_pkt();
        return {2'd3, 14'd0};
    endfunction

    task automatic add_packet(input logic [15:0] pkt);
        pkt_table[pkt_total] = pkt;
        pkt_total++;
    endtask

    task automatic open_test(input logic [8*24-1:0] name, input int exp_count);
        test_first[test_total] = pkt_total;
        test_name[test_total]  = name;
        test_exp[test_total]   = exp_count;
        test_total++;
    endtask

    // header plus a run of mixed sign features
    task automatic add_node(input int id, input int cnt);
        int i;
        add_packet(header_pkt(id, cnt));
        for (i = 0; i < cnt; i++) begin
            add_packet(feature_pkt(((id * 29 + i * 71 + 13) % 256) - 128));
        end
    endtask

    task automatic build_table();
        int mixed [15];
        int i;
        mixed = '{100, -50, 27, -128, 127, 5, -3, 64, -90, 12, 0, -1, 44, -77, 33};
        pkt_total  = 0;
        test_total = 0;
        // weight 1, then a negative feature hits relu
        open_test("single feature relu", 2);
        add_packet(weight_pkt(1));
        add_packet(header_pkt(1, 1));
        add_packet(feature_pkt(37));
        add_packet(header_pkt(2, 1));
        add_packet(feature_pkt(-5));
        add_packet(end_pkt());
        // full count, then negative weight times negative sum
        open_test("fifteen features", 2);
        add_packet(weight_pkt(3));
        add_packet(header_pkt(3, 15));
        for (i = 0; i < 15; i++) begin
            add_packet(feature_pkt(mixed[i]));
        end
        add_packet(weight_pkt(-4));
        add_packet(header_pkt(4, 3));
        add_packet(feature_pkt(-10));
        add_packet(feature_pkt(-20));
        add_packet(feature_pkt(-7));
        add_packet(end_pkt());
        // node 5 keeps weight 2, node 6 gets -3
        open_test("weight between headers", 2);
        add_packet(weight_pkt(2));
        add_packet(header_pkt(5, 2));
        add_packet(feature_pkt(10));
        add_packet(weight_pkt(-3));
        add_packet(feature_pkt(20));
        add_packet(header_pkt(6, 2));
        add_packet(feature_pkt(-4));
        add_packet(feature_pkt(-6));
        add_packet(end_pkt());
        // both PEs busy, results may reorder
        open_test("back to back nodes", 5);
        add_packet(weight_pkt(-2));
        add_node(10, 12);
        add_node(11, 15);
        add_node(12, 9);
        add_node(13, 14);
        add_node(14, 1);
        add_packet(end_pkt());
        // completion falls again with the first header
        open_test("reopen after end", 3);
        add_packet(weight_pkt(5));
        add_node(20, 4);
        add_node(21, 2);
        add_node(22, 7);
        add_packet(end_pkt());
        test_first[test_total] = pkt_total;
    endtask

    // starts and ends on a falling edge
    task automatic send_packet(input logic [15:0] pkt, output bit ok);
        int waited;
        waited = 0;
        while (pkt_ready !== 1'b1 && waited < ready_limit) begin
            @(negedge clk);
            waited++;
        end
        ok = (pkt_ready === 1'b1);
        if (ok) begin
            pkt_valid = 1'b1;
            pkt_data  = pkt;
            @(negedge clk);
            pkt_valid = 1'b0;
        end
    endtask

    task automatic wait_complete(output bit ok);
        int waited;
        waited = 0;
        while (task_complete !== 1'b1 && waited < complete_limit) begin
            @(negedge clk);
            waited++;
        end
        ok = (task_complete === 1'b1);
    endtask

    initial begin
        int t;
        int p;
        int r;
        bit ok;
        bit timed_out;
        arst_n         = 1'b0;
        pkt_valid      = 1'b0;
        pkt_data       = '0;
        test_end       = 1'b0;
        test_label     = '0;
        test_exp_count = '0;
        seed           = 32'h0f144bd4;
        timed_out      = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        for (t = 0; t < test_total && !timed_out; t++) begin
            for (p = test_first[t]; p < test_first[t+1] && !timed_out; p++) begin
                // occasional idle cycles between packets
                r = $random(seed);
                if (r[0]) begin
                    repeat (r[2:1]) @(negedge clk);
                end
                send_packet(pkt_table[p], ok);
                if (!ok) begin
                    $display("timeout: pkt_ready stayed low for %0d cycles in test %0d",
                             ready_limit, t);
                    timed_out = 1'b1;
                end
            end
            if (!timed_out) begin
                wait_complete(ok);
                if (!ok) begin
                    $display("timeout: task_complete never rose in test %0d", t);
                    timed_out = 1'b1;
                end else begin
                    // checker closes the test on the next rising edge
                    test_label     = test_name[t];
                    test_exp_count = 8'(test_exp[t]);
                    test_end       = 1'b1;
                    @(negedge clk);
                    test_end = 1'b0;
                end
            end
        end
        $display("tests %0d, results checked %0d, errors %0d", test_total, check_count,
                 error_count);
        if (timed_out || error_count != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire
